/* rtl/sdram_port_pkg.sv */
package sdram_port_pkg;

  localparam int ADDR_W      = 20;  // word address width
  localparam int DATA_W      = 16;
  localparam int LINE_WORDS  = 4;   // read cache line
  localparam int BLOCK_WORDS = 16;  // stream block
  localparam int LEN_W       = 5;   // burst length field

  localparam int LINE_IDX_W  = $clog2(LINE_WORDS);
  localparam int BLOCK_IDX_W = $clog2(BLOCK_WORDS);
  localparam int TAG_W       = ADDR_W - LINE_IDX_W;
  localparam int BLOCK_NUM_W = ADDR_W - BLOCK_IDX_W;

  // burst lengths per source
  localparam logic [LEN_W-1:0] LEN_FILL   = LEN_W'(LINE_WORDS);
  localparam logic [LEN_W-1:0] LEN_SINGLE = LEN_W'(1);
  localparam logic [LEN_W-1:0] LEN_FLUSH  = LEN_W'(BLOCK_WORDS);

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [LEN_W-1:0]  beat_idx_t;

  typedef struct packed {
    logic [TAG_W-1:0]      tag;   // cache line number
    logic [LINE_IDX_W-1:0] word;  // word within line
  } line_view_t;

  typedef struct packed {
    logic [BLOCK_NUM_W-1:0] num;   // stream block number
    logic [BLOCK_IDX_W-1:0] word;  // word within block
  } block_view_t;

  // one user address, seen by the cache and by the stream buffer
  typedef union packed {
    addr_t       word;
    line_view_t  line;
    block_view_t block;
  } usr_addr_u;

  typedef struct packed {
    addr_t            addr;  // first word of the burst
    logic [LEN_W-1:0] len;   // number of beats
  } burst_cmd_t;

endpackage

/* rtl/burst_sequencer.sv */
`timescale 1ns/1ps

module burst_sequencer (
  input  logic                                    clk,
  input  logic                                    sys_rst_n,
  // line fill source
  input  logic                                    fill_req,
  input  sdram_port_pkg::usr_addr_u               fill_line,
  output logic                                    fill_we,
  output sdram_port_pkg::beat_idx_t               fill_idx,
  output sdram_port_pkg::data_t                   fill_data,
  output logic                                    fill_done,
  // single write source
  input  logic                                    write_req,
  input  sdram_port_pkg::usr_addr_u               address,
  input  sdram_port_pkg::data_t                   data_in,
  output logic                                    write_ack,
  // stream flush source
  input  logic                                    flush_req,
  input  logic [sdram_port_pkg::BLOCK_NUM_W-1:0]  flush_block,
  input  sdram_port_pkg::data_t                   flush_word,
  output sdram_port_pkg::beat_idx_t               flush_idx,
  output logic                                    flush_done,
  // external burst interface
  output logic                                    sdram_rd_req,
  output sdram_port_pkg::burst_cmd_t              sdram_rd_cmd,
  input  logic                                    sdram_rd_ack,
  input  sdram_port_pkg::data_t                   sdram_dout,
  output logic                                    sdram_wr_req,
  output sdram_port_pkg::burst_cmd_t              sdram_wr_cmd,
  input  logic                                    sdram_wr_ack,
  output sdram_port_pkg::data_t                   sdram_din
);
  import sdram_port_pkg::*;

  enum logic [1:0] {ST_IDLE, ST_FILL, ST_SWR, ST_FLUSH} state;

  beat_idx_t        beat;       // acknowledged beats so far
  logic             wr_req_d;
  logic             wr_pend;    // single write waiting for the bus
  logic             beat_ack;
  logic [LEN_W-1:0] cur_len;
  logic             last_beat;
  logic             src_done;   // a source is still seeing its done pulse

  assign beat_ack  = (state == ST_FILL) ? sdram_rd_ack : (state != ST_IDLE) && sdram_wr_ack;
  assign cur_len   = (state == ST_FILL) ? sdram_rd_cmd.len : sdram_wr_cmd.len;
  assign last_beat = (beat == cur_len - 1'b1);
  assign src_done  = fill_done || flush_done;  // its request drops on the next edge

  // read beats go straight into the cache line
  assign fill_we   = (state == ST_FILL) && sdram_rd_ack;
  assign fill_idx  = beat;
  assign fill_data = sdram_dout;

  // write data follows the beat count
  assign flush_idx = beat;
  assign sdram_din = (state == ST_SWR) ? data_in : flush_word;

  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      state        <= ST_IDLE;
      beat         <= '0;
      wr_req_d     <= 1'b0;
      wr_pend      <= 1'b0;
      sdram_rd_req <= 1'b0;
      sdram_wr_req <= 1'b0;
      sdram_rd_cmd <= '0;
      sdram_wr_cmd <= '0;
      fill_done    <= 1'b0;
      write_ack    <= 1'b0;
      flush_done   <= 1'b0;
    end else begin
      wr_req_d   <= write_req;
      fill_done  <= 1'b0;
      write_ack  <= 1'b0;
      flush_done <= 1'b0;
      if (write_req && !wr_req_d) begin
        wr_pend <= 1'b1;
      end
      case (state)
        ST_IDLE: begin
          beat <= '0;
          if (!src_done) begin
            if (fill_req) begin  // fixed priority, fill first
              sdram_rd_cmd <= '{addr: {fill_line.line.tag, {LINE_IDX_W{1'b0}}}, len: LEN_FILL};
              sdram_rd_req <= 1'b1;
              state        <= ST_FILL;
            end else if (wr_pend) begin
              sdram_wr_cmd <= '{addr: address.word, len: LEN_SINGLE};
              sdram_wr_req <= 1'b1;
              wr_pend      <= 1'b0;
              state        <= ST_SWR;
            end else if (flush_req) begin
              sdram_wr_cmd <= '{addr: {flush_block, {BLOCK_IDX_W{1'b0}}}, len: LEN_FLUSH};
              sdram_wr_req <= 1'b1;
              state        <= ST_FLUSH;
            end
          end
        end
        default: begin
          if (beat_ack) begin
            if (last_beat) begin
              sdram_rd_req <= 1'b0;
              sdram_wr_req <= 1'b0;
              fill_done    <= (state == ST_FILL);
              write_ack    <= (state == ST_SWR);
              flush_done   <= (state == ST_FLUSH);
              state        <= ST_IDLE;
            end else begin
              beat <= beat + 1'b1;
            end
          end
        end
      endcase
    end
  end

endmodule

/* rtl/read_line_cache.sv */
`timescale 1ns/1ps

module read_line_cache (
  input  logic                      clk,
  input  logic                      sys_rst_n,
  input  sdram_port_pkg::usr_addr_u address,
  input  logic                      read_req,
  input  logic                      write_req,
  input  logic                      write_en,
  output logic                      fill_req,
  output sdram_port_pkg::usr_addr_u fill_line,
  input  logic                      fill_we,
  input  sdram_port_pkg::beat_idx_t fill_idx,
  input  sdram_port_pkg::data_t     fill_data,
  input  logic                      fill_done,
  output sdram_port_pkg::data_t     data_out,
  output logic                      read_ack
);
  import sdram_port_pkg::*;

  data_t            line_q [LINE_WORDS];
  logic [TAG_W-1:0] tag_q;
  logic             valid_q;
  logic             req_s;
  logic             req_s_d;
  logic             rd_rise;
  logic             hit;

  assign rd_rise = req_s && !req_s_d;  // edge detect costs one cycle
  assign hit     = valid_q && (tag_q == address.line.tag);

  // line storage and tag
  always_ff @(posedge clk) begin
    if (fill_we) begin
      line_q[fill_idx[LINE_IDX_W-1:0]] <= fill_data;
    end
    if (fill_done) begin
      tag_q <= fill_line.line.tag;
    end
    if (rd_rise && !hit) begin
      fill_line <= address;
    end
  end

  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      req_s    <= 1'b0;
      req_s_d  <= 1'b0;
      valid_q  <= 1'b0;
      fill_req <= 1'b0;
      read_ack <= 1'b0;
      data_out <= '0;
    end else begin
      req_s   <= read_req;
      req_s_d <= req_s;
      if (fill_done) begin
        fill_req <= 1'b0;
        valid_q  <= 1'b1;
      end
      if (!read_req) begin
        read_ack <= 1'b0;
        data_out <= '0;
      end else if (rd_rise) begin
        if (hit) begin
          read_ack <= 1'b1;
          data_out <= line_q[address.line.word];
        end else begin
          fill_req <= 1'b1;  // held until the line arrives
          valid_q  <= 1'b0;
        end
      end else if (fill_done) begin
        read_ack <= 1'b1;
        data_out <= line_q[fill_line.line.word];
      end
      // any write may touch the cached line
      if (write_req || write_en) begin
        valid_q <= 1'b0;
      end
    end
  end

endmodule

/* rtl/stream_write_buffer.sv */
`timescale 1ns/1ps

module stream_write_buffer (
  input  logic                                    clk,
  input  logic                                    sys_rst_n,
  input  sdram_port_pkg::usr_addr_u               address,
  input  sdram_port_pkg::data_t                   data_in,
  input  logic                                    write_latch_address,
  input  logic                                    write_en,
  output sdram_port_pkg::addr_t                   write_address,
  output logic                                    flush_req,
  output logic [sdram_port_pkg::BLOCK_NUM_W-1:0]  flush_block,
  input  sdram_port_pkg::beat_idx_t               flush_idx,
  output sdram_port_pkg::data_t                   flush_word,
  input  logic                                    flush_done
);
  import sdram_port_pkg::*;

  addr_t     run_addr;                  // next stream address
  usr_addr_u cur_addr;
  data_t     front_q [BLOCK_WORDS-1];   // last word goes straight to the back buffer
  data_t     back_q  [BLOCK_WORDS];
  logic      block_end;

  assign cur_addr.word = write_latch_address ? address.word : run_addr;
  assign block_end     = write_en && (cur_addr.block.word == BLOCK_IDX_W'(BLOCK_WORDS - 1));
  assign write_address = run_addr;
  assign flush_word    = back_q[flush_idx[BLOCK_IDX_W-1:0]];

  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      run_addr <= '0;
    end else if (write_en) begin
      run_addr <= cur_addr.word + 1'b1;
    end else if (write_latch_address) begin
      run_addr <= address.word;  // latch without a store
    end
  end

  // block buffers
  always_ff @(posedge clk) begin
    if (write_en) begin
      if (block_end) begin
        for (int i = 0; i < BLOCK_WORDS - 1; i++) begin
          back_q[i] <= front_q[i];
        end
        back_q[BLOCK_WORDS-1] <= data_in;
        flush_block           <= cur_addr.block.num;
      end else begin
        front_q[cur_addr.block.word] <= data_in;
      end
    end
  end

  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      flush_req <= 1'b0;
    end else if (block_end) begin
      flush_req <= 1'b1;  // new block ready for the sequencer
    end else if (flush_done) begin
      flush_req <= 1'b0;
    end
  end

endmodule

/* rtl/sdram_port_top.sv */
`timescale 1ns/1ps

module sdram_port_top (
  input  logic                      clk,
  input  logic                      sys_rst_n,
  input  sdram_port_pkg::usr_addr_u address,
  input  sdram_port_pkg::data_t     data_in,
  output sdram_port_pkg::data_t     data_out,
  input  logic                      read_req,
  output logic                      read_ack,
  input  logic                      write_req,
  output logic                      write_ack,
  input  logic                      write_latch_address,
  input  logic                      write_en,
  output sdram_port_pkg::addr_t     write_address,
  output logic                      sdram_rd_req,
  input  logic                      sdram_rd_ack,
  output sdram_port_pkg::burst_cmd_t sdram_rd_cmd,
  input  sdram_port_pkg::data_t     sdram_dout,
  output logic                      sdram_wr_req,
  input  logic                      sdram_wr_ack,
  output sdram_port_pkg::burst_cmd_t sdram_wr_cmd,
  output sdram_port_pkg::data_t     sdram_din
);
  import sdram_port_pkg::*;

  logic                   fill_req;
  usr_addr_u              fill_line;
  logic                   fill_we;
  beat_idx_t              fill_idx;
  data_t                  fill_data;
  logic                   fill_done;
  logic                   flush_req;
  logic [BLOCK_NUM_W-1:0] flush_block;
  data_t                  flush_word;
  beat_idx_t              flush_idx;
  logic                   flush_done;

  burst_sequencer u_seq (
    .clk          (clk),
    .sys_rst_n    (sys_rst_n),
    .fill_req     (fill_req),
    .fill_line    (fill_line),
    .fill_we      (fill_we),
    .fill_idx     (fill_idx),
    .fill_data    (fill_data),
    .fill_done    (fill_done),
    .write_req    (write_req),
    .address      (address),
    .data_in      (data_in),
    .write_ack    (write_ack),
    .flush_req    (flush_req),
    .flush_block  (flush_block),
    .flush_word   (flush_word),
    .flush_idx    (flush_idx),
    .flush_done   (flush_done),
    .sdram_rd_req (sdram_rd_req),
    .sdram_rd_cmd (sdram_rd_cmd),
    .sdram_rd_ack (sdram_rd_ack),
    .sdram_dout   (sdram_dout),
    .sdram_wr_req (sdram_wr_req),
    .sdram_wr_cmd (sdram_wr_cmd),
    .sdram_wr_ack (sdram_wr_ack),
    .sdram_din    (sdram_din)
  );

  read_line_cache u_cache (
    .clk       (clk),
    .sys_rst_n (sys_rst_n),
    .address   (address),
    .read_req  (read_req),
    .write_req (write_req),
    .write_en  (write_en),
    .fill_req  (fill_req),
    .fill_line (fill_line),
    .fill_we   (fill_we),
    .fill_idx  (fill_idx),
    .fill_data (fill_data),
    .fill_done (fill_done),
    .data_out  (data_out),
    .read_ack  (read_ack)
  );

  stream_write_buffer u_stream (
    .clk                 (clk),
    .sys_rst_n           (sys_rst_n),
    .address             (address),
    .data_in             (data_in),
    .write_latch_address (write_latch_address),
    .write_en            (write_en),
    .write_address       (write_address),
    .flush_req           (flush_req),
    .flush_block         (flush_block),
    .flush_idx           (flush_idx),
    .flush_word          (flush_word),
    .flush_done          (flush_done)
  );

endmodule

/* dv/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 2
) (
  output logic clk,
  output logic sys_rst_n
);

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clk = ~clk;
    end
  end

  initial begin
    sys_rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2 sys_rst_n = 1'b1;  // released off the edge
  end

endmodule

/* dv/burst_mem_model.sv */
`timescale 1ns/1ps

module burst_mem_model (
  input  logic                       clk,
  input  logic                       sys_rst_n,
  input  logic                       sdram_rd_req,
  input  sdram_port_pkg::burst_cmd_t sdram_rd_cmd,
  output logic                       sdram_rd_ack,
  output sdram_port_pkg::data_t      sdram_dout,
  input  logic                       sdram_wr_req,
  input  sdram_port_pkg::burst_cmd_t sdram_wr_cmd,
  output logic                       sdram_wr_ack,
  input  sdram_port_pkg::data_t      sdram_din,
  input  int                         gap,       // cycles before the first beat
  input  int                         beat_gap   // idle cycles between beats
);
  import sdram_port_pkg::*;

  addr_t used_addr [$];  // written locations only
  data_t used_data [$];

  // words never written read back a pattern of their full address
  function automatic data_t peek(input addr_t a);
    data_t d;
    d = a[15:0] ^ {4{a[19:16]}};
    for (int i = 0; i < used_addr.size(); i++) begin
      if (used_addr[i] == a) begin
        d = used_data[i];
      end
    end
    return d;
  endfunction

  task automatic store(input addr_t a, input data_t d);
    logic found;
    found = 1'b0;
    for (int i = 0; i < used_addr.size(); i++) begin
      if (used_addr[i] == a) begin
        used_data[i] = d;
        found        = 1'b1;
      end
    end
    if (!found) begin
      used_addr.push_back(a);
      used_data.push_back(d);
    end
  endtask

  task automatic serve(input logic is_read, input burst_cmd_t cmd);
    addr_t a;
    for (int i = 0; i < int'(cmd.len); i++) begin
      a = cmd.addr + addr_t'(i);
      repeat ((i == 0) ? gap : beat_gap) begin
        @(posedge clk);
        #2;
      end
      if (is_read) begin
        sdram_dout   = peek(a);
        sdram_rd_ack = 1'b1;
      end else begin
        sdram_wr_ack = 1'b1;
      end
      @(negedge clk);
      if (!is_read) begin
        store(a, sdram_din);  // beat data is stable until the acked edge
      end
      @(posedge clk);
      #2;
      sdram_rd_ack = 1'b0;
      sdram_wr_ack = 1'b0;
    end
  endtask

  initial begin
    sdram_rd_ack = 1'b0;
    sdram_wr_ack = 1'b0;
    sdram_dout   = '0;
    forever begin
      @(posedge clk);
      #2;
      if (sys_rst_n && sdram_rd_req) begin
        serve(1'b1, sdram_rd_cmd);
      end else if (sys_rst_n && sdram_wr_req) begin
        serve(1'b0, sdram_wr_cmd);
      end
    end
  end

endmodule

/* dv/sdram_port_tb.sv */
`timescale 1ns/1ps

module sdram_port_tb;
  import sdram_port_pkg::*;

  localparam int WAIT_LIMIT = 200;  // cycles per wait

  logic        clk;
  logic        sys_rst_n;
  usr_addr_u   address;
  data_t       data_in;
  data_t       data_out;
  logic        read_req;
  logic        read_ack;
  logic        write_req;
  logic        write_ack;
  logic        write_latch_address;
  logic        write_en;
  addr_t       write_address;
  logic        sdram_rd_req;
  logic        sdram_rd_ack;
  burst_cmd_t  sdram_rd_cmd;
  data_t       sdram_dout;
  logic        sdram_wr_req;
  logic        sdram_wr_ack;
  burst_cmd_t  sdram_wr_cmd;
  data_t       sdram_din;
  int          mem_gap;
  int          mem_beat_gap;
  logic [31:0] rng_state;
  int          errors;
  int          checks;
  int          tests;
  int          err_mark;
  addr_t       stream_base;
  data_t       stream_data [32];

  tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(2)) clk_gen_i (
    .clk       (clk),
    .sys_rst_n (sys_rst_n)
  );

  burst_mem_model mem_i (
    .gap      (mem_gap),
    .beat_gap (mem_beat_gap),
    .*
  );

  sdram_port_top dut_i (.*);

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic check_data(input string name, input data_t got, input data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_cmd(input string name, input burst_cmd_t got, input burst_cmd_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic note_failure(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  task automatic report_test(input string name);
    tests++;
    if (errors == err_mark) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  task automatic pick_gaps();
    logic [31:0] r;
    r            = next_rand();
    mem_gap      = int'(r[2:0]) % 5;
    mem_beat_gap = int'(r[9:8]) % 3;
  endtask

  task automatic write_single(input addr_t a, input data_t d);
    int         n;
    logic       got;
    logic       cmd_seen;
    burst_cmd_t exp_cmd;
    n            = 0;
    got          = 1'b0;
    cmd_seen     = 1'b0;
    exp_cmd.addr = a;
    exp_cmd.len  = LEN_W'(1);
    pick_gaps();
    @(posedge clk);
    #2;
    address.word = a;
    data_in      = d;
    write_req    = 1'b1;
    while (!got && n < WAIT_LIMIT) begin
      @(posedge clk);
      @(negedge clk);
      if (sdram_wr_req && !cmd_seen) begin
        check_cmd("sdram_wr_cmd", sdram_wr_cmd, exp_cmd);
        check_data("sdram_din", sdram_din, d);  // beat 0 from the request edge
        cmd_seen = 1'b1;
      end
      got = write_ack;
      n++;
    end
    if (!got) begin
      note_failure($sformatf("single write to %h was never acknowledged", a));
    end
    @(posedge clk);
    #2;
    write_req = 1'b0;
    @(negedge clk);
    check_bit("write_ack", write_ack, 1'b0);  // one cycle pulse
  endtask

  task automatic read_word(input addr_t a, output data_t d, output int edges,
                           output logic rd_seen);
    int         n;
    logic       got;
    burst_cmd_t exp_cmd;
    n            = 0;
    got          = 1'b0;
    d            = '0;
    edges        = 0;
    rd_seen      = 1'b0;
    exp_cmd.addr = {a[19:2], 2'b00};  // whole line
    exp_cmd.len  = LEN_W'(4);
    pick_gaps();
    @(posedge clk);
    #2;
    address.word = a;
    read_req     = 1'b1;
    while (!got && n < WAIT_LIMIT) begin
      @(posedge clk);
      edges++;
      @(negedge clk);
      if (sdram_rd_req && !rd_seen) begin
        check_cmd("sdram_rd_cmd", sdram_rd_cmd, exp_cmd);
      end
      rd_seen = rd_seen | sdram_rd_req;
      got     = read_ack;
      d       = data_out;
      n++;
    end
    if (!got) begin
      note_failure($sformatf("read of %h got no read_ack", a));
    end
    @(posedge clk);
    #2;
    read_req = 1'b0;
    @(posedge clk);
    @(negedge clk);
    check_bit("read_ack", read_ack, 1'b0);
    check_data("data_out", data_out, '0);
  endtask

  task automatic latch_stream_address(input addr_t a);
    @(posedge clk);
    #2;
    address.word        = a;
    write_latch_address = 1'b1;
    @(posedge clk);
    #2;
    write_latch_address = 1'b0;
  endtask

  // stores stream_data[first..] with random idle cycles in between
  task automatic stream_words(input int first, input int count);
    logic [31:0] r;
    int          i;
    i = first;
    while (i < first + count) begin
      @(posedge clk);
      #2;
      r = next_rand();
      if (r[1:0] == 2'b00) begin
        write_en = 1'b0;
      end else begin
        write_en = 1'b1;
        data_in  = stream_data[i];
        i++;
      end
    end
    @(posedge clk);
    #2;
    write_en = 1'b0;
  endtask

  task automatic wait_flush_done(input addr_t blk_base);
    int         n;
    logic       cmd_seen;
    burst_cmd_t exp_cmd;
    n            = 0;
    cmd_seen     = 1'b0;
    exp_cmd.addr = blk_base;
    exp_cmd.len  = LEN_W'(16);
    while (!dut_i.flush_req && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    while (dut_i.flush_req && n < WAIT_LIMIT) begin
      @(negedge clk);
      if (sdram_wr_req && !cmd_seen) begin
        check_cmd("sdram_wr_cmd", sdram_wr_cmd, exp_cmd);
        cmd_seen = 1'b1;
      end
      n++;
    end
    if (n >= WAIT_LIMIT) begin
      note_failure("stream block flush did not finish in time");
    end
  endtask

  task automatic test_reset_state();
    int n;
    n = 0;
    while (!sys_rst_n && n < WAIT_LIMIT) begin
      @(posedge clk);
      n++;
    end
    if (!sys_rst_n) begin
      note_failure("reset was never released");
    end
    @(negedge clk);
    check_bit("read_ack", read_ack, 1'b0);
    check_bit("write_ack", write_ack, 1'b0);
    check_bit("sdram_rd_req", sdram_rd_req, 1'b0);
    check_bit("sdram_wr_req", sdram_wr_req, 1'b0);
    check_data("data_out", data_out, '0);
    check_addr("write_address", write_address, '0);
  endtask

  task automatic test_write_then_read();
    addr_t       wa [6];
    data_t       wd [6];
    data_t       exp;
    data_t       got;
    int          edges;
    logic        rd_seen;
    logic [31:0] r;
    for (int i = 0; i < 6; i++) begin
      r     = next_rand();
      wa[i] = r[19:0];
      r     = next_rand();
      wd[i] = r[15:0];
      write_single(wa[i], wd[i]);
    end
    for (int i = 0; i < 6; i++) begin
      exp = wd[i];
      for (int j = 0; j < 6; j++) begin
        if (wa[j] == wa[i]) begin
          exp = wd[j];  // last write to a repeated address wins
        end
      end
      read_word(wa[i], got, edges, rd_seen);
      check_data("data_out", got, exp);
    end
  endtask

  task automatic test_read_hit();
    addr_t       base;
    addr_t       a;
    data_t       got;
    int          edges;
    logic        rd_seen;
    logic [31:0] r;
    r    = next_rand();
    base = {r[19:2], 2'b00};
    read_word(base, got, edges, rd_seen);
    check_data("data_out", got, mem_i.peek(base));
    for (int i = 1; i < LINE_WORDS; i++) begin
      a = base + addr_t'(i);
      read_word(a, got, edges, rd_seen);
      check_data("data_out", got, mem_i.peek(a));
      check_bit("sdram_rd_req", rd_seen, 1'b0);
      if (edges != 2) begin
        note_failure($sformatf("read hit at %h took %0d edges instead of 2", a, edges));
      end
    end
  endtask

  task automatic test_invalidation();
    addr_t       base;
    addr_t       a;
    data_t       got;
    data_t       new_val;
    int          edges;
    logic        rd_seen;
    logic [31:0] r;
    r    = next_rand();
    base = {r[19:2], 2'b00};
    a    = base + addr_t'(r[21:20]);
    read_word(base, got, edges, rd_seen);
    check_data("data_out", got, mem_i.peek(base));
    new_val = mem_i.peek(a) ^ (r[31:16] | 16'h0001);  // always differs from memory
    write_single(a, new_val);
    read_word(a, got, edges, rd_seen);
    check_data("data_out", got, new_val);
  endtask

  task automatic test_streaming();
    data_t       got;
    int          edges;
    logic        rd_seen;
    logic [31:0] r;
    r           = next_rand();
    stream_base = {r[19:4], 4'h0};
    for (int i = 0; i < 32; i++) begin
      r              = next_rand();
      stream_data[i] = r[15:0];
    end
    latch_stream_address(stream_base);
    check_addr("write_address", write_address, stream_base);
    for (int blk = 0; blk < 2; blk++) begin
      stream_words(blk * BLOCK_WORDS, BLOCK_WORDS);
      wait_flush_done(stream_base + addr_t'(blk * 16));
      check_addr("write_address", write_address, stream_base + addr_t'((blk + 1) * 16));
    end
    for (int i = 0; i < 32; i++) begin
      read_word(stream_base + addr_t'(i), got, edges, rd_seen);
      check_data("data_out", got, stream_data[i]);
    end
  endtask

  task automatic test_partial_block();
    addr_t       base;
    data_t       prev [8];
    data_t       got;
    int          edges;
    logic        rd_seen;
    logic [31:0] r;
    base = stream_base + addr_t'(64);  // block untouched so far
    for (int i = 0; i < 8; i++) begin
      prev[i]        = mem_i.peek(base + addr_t'(i));
      r              = next_rand();
      stream_data[i] = r[15:0];
    end
    latch_stream_address(base);
    stream_words(0, 8);
    @(negedge clk);
    check_bit("flush_req", dut_i.flush_req, 1'b0);
    check_addr("write_address", write_address, base + addr_t'(8));
    for (int i = 0; i < 8; i++) begin
      read_word(base + addr_t'(i), got, edges, rd_seen);
      check_data("data_out", got, prev[i]);
    end
  endtask

  initial begin
    address             = '0;
    data_in             = '0;
    read_req            = 1'b0;
    write_req           = 1'b0;
    write_latch_address = 1'b0;
    write_en            = 1'b0;
    mem_gap             = 0;
    mem_beat_gap        = 0;
    rng_state           = 32'hcb64;
    errors              = 0;
    checks              = 0;
    tests               = 0;
    err_mark            = 0;
    stream_base         = '0;

    test_reset_state();
    report_test("reset_state");
    test_write_then_read();
    report_test("write_then_read");
    test_read_hit();
    report_test("read_hit");
    test_invalidation();
    report_test("invalidation");
    test_streaming();
    report_test("streaming");
    test_partial_block();
    report_test("partial_block");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* files.f */
rtl/sdram_port_pkg.sv
rtl/burst_sequencer.sv
rtl/read_line_cache.sv
rtl/stream_write_buffer.sv
rtl/sdram_port_top.sv
dv/tb_clock_gen.sv
dv/burst_mem_model.sv
dv/sdram_port_tb.sv
